//--- tb.f
logic/mm_pkg.sv
logic/mem_req_if.sv
logic/sp_ram.sv
logic/mem_arbiter.sv
logic/data_decoder.sv
logic/sim_ctrl_regs.sv
logic/mm_ram_top.sv
tb/mm_ram_asserts.sv
tb/tb_mm_ram.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the memory system testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mm_ram \
    -f tb.f \
    -o sim_tb_mm_ram

# the simulator exits non-zero on a fatal error, the search below decides
output="$(./obj_dir/sim_tb_mm_ram 2>&1)" || true
echo "$output"

if grep -qx "STATUS: PASS" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- tb/tb_mm_ram.sv
`timescale 1ns/1ps

module tb_mm_ram;
    import mm_pkg::*;

    localparam int RAM_ADDR_WIDTH = 12;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int TIMER_TICKS    = 6;

    // handshake signals polled by the wait loop
    localparam int SIG_DATA_GNT     = 0;
    localparam int SIG_DATA_RVALID  = 1;
    localparam int SIG_INSTR_GNT    = 2;
    localparam int SIG_INSTR_RVALID = 3;

    logic    clk_i;
    logic    rst_ni;
    logic    instr_req_i;
    word_t   instr_addr_i;
    logic    instr_gnt_o;
    logic    instr_rvalid_o;
    word_t   instr_rdata_o;
    logic    data_req_i;
    word_t   data_addr_i;
    logic    data_we_i;
    be_t     data_be_i;
    word_t   data_wdata_i;
    logic    data_gnt_o;
    logic    data_rvalid_o;
    word_t   data_rdata_o;
    irq_id_t irq_id_i;
    logic    irq_ack_i;
    logic    irq_timer_o;
    logic    tests_passed_o;
    logic    tests_failed_o;
    logic    exit_valid_o;
    word_t   exit_value_o;

    word_t   lfsr_state;

    mm_ram_top #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_mm_ram_top (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .irq_id_i       (irq_id_i),
        .irq_ack_i      (irq_ack_i),
        .irq_timer_o    (irq_timer_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1
    // one shift per output bit
    function automatic word_t next_random();
        logic  fb;
        word_t value;
        value = '0;
        for (int i = 0; i < 32; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic handshake_level(input int sel);
        case (sel)
            SIG_DATA_GNT:     return data_gnt_o;
            SIG_DATA_RVALID:  return data_rvalid_o;
            SIG_INSTR_GNT:    return instr_gnt_o;
            SIG_INSTR_RVALID: return instr_rvalid_o;
            default:          return 1'b0;
        endcase
    endfunction

    // inputs change 1 ns after the edge and outputs are sampled 2 ns after it
    task automatic drive_edge();
        @(posedge clk_i);
        #1;
    endtask

    task automatic wait_for_signal(input int sel, input string what);
        int cycles;
        cycles = 0;
        while (!handshake_level(sel)) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout after %0d cycles waiting for %s", cycles, what);
                stop_with_failure();
            end else begin
                @(posedge clk_i);
                #2;
                cycles++;
            end
        end
    endtask

    task automatic data_access(input word_t addr, input logic we, input be_t be,
                               input word_t wdata, output word_t rdata);
        drive_edge();
        data_req_i   = 1'b1;
        data_addr_i  = addr;
        data_we_i    = we;
        data_be_i    = be;
        data_wdata_i = wdata;
        #1;
        wait_for_signal(SIG_DATA_GNT, "data_gnt_o");
        drive_edge();
        data_req_i = 1'b0;
        data_we_i  = 1'b0;
        #1;
        wait_for_signal(SIG_DATA_RVALID, "data_rvalid_o");
        rdata = data_rdata_o;
    endtask

    task automatic data_write(input word_t addr, input be_t be, input word_t wdata);
        word_t unused_rdata;
        data_access(addr, 1'b1, be, wdata, unused_rdata);
    endtask

    task automatic data_read(input word_t addr, output word_t rdata);
        data_access(addr, 1'b0, 4'hF, 32'h0, rdata);
    endtask

    task automatic instr_fetch(input word_t addr, output word_t rdata);
        drive_edge();
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
        #1;
        wait_for_signal(SIG_INSTR_GNT, "instr_gnt_o");
        drive_edge();
        instr_req_i = 1'b0;
        #1;
        wait_for_signal(SIG_INSTR_RVALID, "instr_rvalid_o");
        rdata = instr_rdata_o;
    endtask

    task automatic test_byte_enables();
        word_t first;
        word_t second;
        word_t got;
        word_t merged;
        first  = next_random();
        second = next_random();
        // be 4'b0101 replaces bytes 0 and 2 and keeps bytes 1 and 3
        merged = {first[31:24], second[23:16], first[15:8], second[7:0]};
        data_write(32'h40, 4'hF, first);
        data_read(32'h40, got);
        check_value("data_rdata_o", got, first);
        data_write(32'h40, 4'b0101, second);
        data_read(32'h40, got);
        check_value("data_rdata_o", got, merged);
    endtask

    task automatic test_shared_ram();
        word_t code_word;
        word_t data_word;
        word_t got;
        code_word = next_random();
        data_word = next_random();
        data_write(32'h80, 4'hF, code_word);
        data_write(32'h84, 4'hF, data_word);
        instr_fetch(32'h80, got);
        check_value("instr_rdata_o", got, code_word);
        // data port wins when both ports request in one cycle
        drive_edge();
        instr_req_i  = 1'b1;
        instr_addr_i = 32'h80;
        data_req_i   = 1'b1;
        data_addr_i  = 32'h84;
        data_we_i    = 1'b0;
        data_be_i    = 4'hF;
        #1;
        check_value("data_gnt_o", word_t'(data_gnt_o), 32'h1);
        check_value("instr_gnt_o", word_t'(instr_gnt_o), 32'h0);
        drive_edge();
        data_req_i = 1'b0;
        #1;
        wait_for_signal(SIG_DATA_RVALID, "data_rvalid_o");
        check_value("data_rdata_o", data_rdata_o, data_word);
        // held fetch goes through once the data port is idle
        wait_for_signal(SIG_INSTR_GNT, "instr_gnt_o");
        drive_edge();
        instr_req_i = 1'b0;
        #1;
        wait_for_signal(SIG_INSTR_RVALID, "instr_rvalid_o");
        check_value("instr_rdata_o", instr_rdata_o, code_word);
    endtask

    task automatic status_case(input word_t value, input logic exp_pass, input logic exp_fail);
        data_write(ADDR_STATUS, 4'hF, value);
        check_value("tests_passed_o", word_t'(tests_passed_o), word_t'(exp_pass));
        check_value("tests_failed_o", word_t'(tests_failed_o), word_t'(exp_fail));
        @(posedge clk_i);
        #2;
        check_value("tests_passed_o", word_t'(tests_passed_o), 32'h0);
        check_value("tests_failed_o", word_t'(tests_failed_o), 32'h0);
    endtask

    task automatic test_status();
        status_case(32'd123456789, 1'b1, 1'b0);
        status_case(32'd1, 1'b0, 1'b1);
        status_case(32'd2, 1'b0, 1'b0);
    endtask

    task automatic test_exit();
        word_t value;
        value = next_random();
        data_write(ADDR_EXIT, 4'hF, value);
        check_value("exit_valid_o", word_t'(exit_valid_o), 32'h1);
        check_value("exit_value_o", exit_value_o, value);
        @(posedge clk_i);
        #2;
        check_value("exit_valid_o", word_t'(exit_valid_o), 32'h0);
    endtask

    task automatic test_timer();
        word_t mask;
        mask = '0;
        mask[7] = 1'b1;
        data_write(ADDR_TIMER_MASK, 4'hF, mask);
        data_write(ADDR_TIMER_CNT, 4'hF, word_t'(TIMER_TICKS));
        // irq comes with the N-th edge after the accepting one
        for (int k = 0; k < TIMER_TICKS; k++) begin
            check_value("irq_timer_o", word_t'(irq_timer_o), 32'h0);
            @(posedge clk_i);
            #2;
        end
        check_value("irq_timer_o", word_t'(irq_timer_o), 32'h1);
        // an acknowledge for another id leaves it set
        drive_edge();
        irq_ack_i = 1'b1;
        irq_id_i  = 5'd3;
        drive_edge();
        irq_id_i = 5'd7;
        #1;
        check_value("irq_timer_o", word_t'(irq_timer_o), 32'h1);
        drive_edge();
        irq_ack_i = 1'b0;
        irq_id_i  = '0;
        #1;
        check_value("irq_timer_o", word_t'(irq_timer_o), 32'h0);
        // masked timer stays quiet
        data_write(ADDR_TIMER_MASK, 4'hF, 32'h0);
        data_write(ADDR_TIMER_CNT, 4'hF, word_t'(TIMER_TICKS));
        for (int k = 0; k < TIMER_TICKS + 5; k++) begin
            check_value("irq_timer_o", word_t'(irq_timer_o), 32'h0);
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic test_unmapped_read();
        word_t got;
        data_read(32'h3000_0000, got);
        check_value("data_rdata_o", got, 32'h0);
    endtask

    initial begin
        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        irq_id_i     = '0;
        irq_ack_i    = 1'b0;
        lfsr_state   = 32'd37;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        #1;
        check_value("irq_timer_o", word_t'(irq_timer_o), 32'h0);
        check_value("data_rvalid_o", word_t'(data_rvalid_o), 32'h0);
        check_value("instr_rvalid_o", word_t'(instr_rvalid_o), 32'h0);
        test_byte_enables();
        test_shared_ram();
        test_status();
        test_exit();
        test_timer();
        test_unmapped_read();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- tb/mm_ram_asserts.sv
`timescale 1ns/1ps

module mm_ram_asserts (
    input logic clk_i,
    input logic rst_ni,
    input logic instr_gnt_i,
    input logic data_gnt_i,
    input logic instr_rvalid_i,
    input logic data_rvalid_i,
    input logic wr_req_i,
    input logic wr_mapped_i
);

    // the shared RAM takes one request per cycle
    a_single_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(instr_gnt_i && data_gnt_i))
        else $error("instruction and data port granted in the same cycle");

    // a response comes exactly in the cycle after each grant
    a_instr_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_rvalid_i == $past(instr_gnt_i))
        else $error("instruction rvalid not in the cycle right after its grant");

    a_data_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_rvalid_i == $past(data_gnt_i))
        else $error("data rvalid not in the cycle right after its grant");

    a_mapped_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_req_i |-> wr_mapped_i)
        else $error("data write to an unmapped address");

endmodule

bind mem_arbiter mm_ram_asserts u_arbiter_asserts (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_gnt_i    (instr_gnt),
    .data_gnt_i     (data_gnt),
    .instr_rvalid_i (instr_bus.rvalid),
    .data_rvalid_i  (data_bus.rvalid),
    .wr_req_i       (1'b0),
    .wr_mapped_i    (1'b1)
);

bind data_decoder mm_ram_asserts u_decoder_asserts (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_gnt_i    (1'b0),
    .data_gnt_i     (1'b0),
    .instr_rvalid_i (1'b0),
    .data_rvalid_i  (1'b0),
    .wr_req_i       (data_req_i & data_we_i),
    .wr_mapped_i    (is_ram | status_we_o | exit_we_o | timer_mask_we_o | timer_cnt_we_o)
);

//--- logic/mm_ram_top.sv
`timescale 1ns/1ps

module mm_ram_top #(
    parameter int RAM_ADDR_WIDTH = 12
) (
    input  logic            clk_i,
    input  logic            rst_ni,

    input  logic            instr_req_i,
    input  mm_pkg::word_t   instr_addr_i,
    output logic            instr_gnt_o,
    output logic            instr_rvalid_o,
    output mm_pkg::word_t   instr_rdata_o,

    input  logic            data_req_i,
    input  mm_pkg::word_t   data_addr_i,
    input  logic            data_we_i,
    input  mm_pkg::be_t     data_be_i,
    input  mm_pkg::word_t   data_wdata_i,
    output logic            data_gnt_o,
    output logic            data_rvalid_o,
    output mm_pkg::word_t   data_rdata_o,

    input  mm_pkg::irq_id_t irq_id_i,
    input  logic            irq_ack_i,
    output logic            irq_timer_o,

    output logic            tests_passed_o,
    output logic            tests_failed_o,
    output logic            exit_valid_o,
    output mm_pkg::word_t   exit_value_o
);
    import mm_pkg::*;

    logic  status_we;
    logic  exit_we;
    logic  timer_mask_we;
    logic  timer_cnt_we;
    word_t ctrl_wdata;

    mem_req_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) instr_bus ();
    mem_req_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) data_bus ();
    mem_req_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) ram_bus ();

    // the fetch port only ever reads whole words
    assign instr_bus.req   = instr_req_i;
    assign instr_bus.addr  = instr_addr_i[RAM_ADDR_WIDTH-1:0];
    assign instr_bus.we    = 1'b0;
    assign instr_bus.be    = '1;
    assign instr_bus.wdata = '0;
    assign instr_gnt_o     = instr_bus.gnt;
    assign instr_rvalid_o  = instr_bus.rvalid;
    assign instr_rdata_o   = instr_bus.rdata;

    mem_arbiter #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_mem_arbiter (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .instr_bus (instr_bus),
        .data_bus  (data_bus),
        .ram_bus   (ram_bus)
    );

    sp_ram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_sp_ram (
        .clk_i   (clk_i),
        .ram_bus (ram_bus)
    );

    data_decoder #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_data_decoder (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .data_req_i      (data_req_i),
        .data_addr_i     (data_addr_i),
        .data_we_i       (data_we_i),
        .data_be_i       (data_be_i),
        .data_wdata_i    (data_wdata_i),
        .data_gnt_o      (data_gnt_o),
        .data_rvalid_o   (data_rvalid_o),
        .data_rdata_o    (data_rdata_o),
        .data_bus        (data_bus),
        .status_we_o     (status_we),
        .exit_we_o       (exit_we),
        .timer_mask_we_o (timer_mask_we),
        .timer_cnt_we_o  (timer_cnt_we),
        .ctrl_wdata_o    (ctrl_wdata)
    );

    sim_ctrl_regs u_sim_ctrl_regs (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .status_we_i     (status_we),
        .exit_we_i       (exit_we),
        .timer_mask_we_i (timer_mask_we),
        .timer_cnt_we_i  (timer_cnt_we),
        .ctrl_wdata_i    (ctrl_wdata),
        .irq_id_i        (irq_id_i),
        .irq_ack_i       (irq_ack_i),
        .tests_passed_o  (tests_passed_o),
        .tests_failed_o  (tests_failed_o),
        .exit_valid_o    (exit_valid_o),
        .exit_value_o    (exit_value_o),
        .irq_timer_o     (irq_timer_o)
    );

endmodule

//--- logic/sim_ctrl_regs.sv
`timescale 1ns/1ps

module sim_ctrl_regs (
    input  logic            clk_i,
    input  logic            rst_ni,

    input  logic            status_we_i,
    input  logic            exit_we_i,
    input  logic            timer_mask_we_i,
    input  logic            timer_cnt_we_i,
    input  mm_pkg::word_t   ctrl_wdata_i,

    input  mm_pkg::irq_id_t irq_id_i,
    input  logic            irq_ack_i,

    output logic            tests_passed_o,
    output logic            tests_failed_o,
    output logic            exit_valid_o,
    output mm_pkg::word_t   exit_value_o,
    output logic            irq_timer_o
);
    import mm_pkg::*;

    logic  passed_q;
    logic  failed_q;
    logic  exit_valid_q;
    word_t exit_value_q;
    word_t timer_mask_q;
    word_t timer_cnt_q;
    logic  irq_timer_q;

    // status and exit pulses follow the write by one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            passed_q     <= 1'b0;
            failed_q     <= 1'b0;
            exit_valid_q <= 1'b0;
        end else begin
            passed_q     <= status_we_i && (ctrl_wdata_i == STATUS_PASS_CODE);
            failed_q     <= status_we_i && (ctrl_wdata_i == STATUS_FAIL_CODE);
            exit_valid_q <= exit_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exit_we_i) begin
            exit_value_q <= ctrl_wdata_i;
        end
    end

    // countdown timer holds while it is being written
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_mask_q <= '0;
            timer_cnt_q  <= '0;
            irq_timer_q  <= 1'b0;
        end else begin
            if (timer_mask_we_i) begin
                timer_mask_q <= ctrl_wdata_i;
            end else if (timer_cnt_we_i) begin
                timer_cnt_q <= ctrl_wdata_i;
            end else begin
                if (timer_cnt_q > 0) begin
                    timer_cnt_q <= timer_cnt_q - 1;
                end
                // fire on the step from one to zero
                if (timer_cnt_q == 1 && timer_mask_q[TIMER_IRQ_ID]) begin
                    irq_timer_q <= 1'b1;
                end
            end
            if (irq_ack_i && (irq_id_i == TIMER_IRQ_ID)) begin
                irq_timer_q <= 1'b0;
            end
        end
    end

    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;
    assign irq_timer_o    = irq_timer_q;

endmodule

//--- logic/data_decoder.sv
`timescale 1ns/1ps

module data_decoder #(
    parameter int RAM_ADDR_WIDTH = 12
) (
    input  logic          clk_i,
    input  logic          rst_ni,

    input  logic          data_req_i,
    input  mm_pkg::word_t data_addr_i,
    input  logic          data_we_i,
    input  mm_pkg::be_t   data_be_i,
    input  mm_pkg::word_t data_wdata_i,
    output logic          data_gnt_o,
    output logic          data_rvalid_o,
    output mm_pkg::word_t data_rdata_o,

    mem_req_if.requester  data_bus,

    output logic          status_we_o,
    output logic          exit_we_o,
    output logic          timer_mask_we_o,
    output logic          timer_cnt_we_o,
    output mm_pkg::word_t ctrl_wdata_o
);
    import mm_pkg::*;

    // first byte address beyond the RAM
    localparam word_t RAM_LIMIT = word_t'(2 ** RAM_ADDR_WIDTH);

    logic      is_ram;
    logic      ctrl_write;
    logic      local_valid_q;
    resp_sel_e resp_sel_d;
    resp_sel_e resp_sel_q;

    assign is_ram = (data_addr_i < RAM_LIMIT);

    // RAM accesses go through the arbiter
    assign data_bus.req   = data_req_i & is_ram;
    assign data_bus.addr  = data_addr_i[RAM_ADDR_WIDTH-1:0];
    assign data_bus.we    = data_we_i;
    assign data_bus.be    = data_be_i;
    assign data_bus.wdata = data_wdata_i;

    // everything outside the RAM is accepted at once
    assign data_gnt_o = is_ram ? data_bus.gnt : data_req_i;

    // strobes for the control locations
    assign ctrl_write      = data_req_i & data_we_i & ~is_ram;
    assign status_we_o     = ctrl_write && (data_addr_i == ADDR_STATUS);
    assign exit_we_o       = ctrl_write && (data_addr_i == ADDR_EXIT);
    assign timer_mask_we_o = ctrl_write && (data_addr_i == ADDR_TIMER_MASK);
    assign timer_cnt_we_o  = ctrl_write && (data_addr_i == ADDR_TIMER_CNT);
    assign ctrl_wdata_o    = data_wdata_i;

    always_comb begin
        if (data_req_i && is_ram) begin
            resp_sel_d = RESP_RAM;
        end else begin
            resp_sel_d = RESP_CTRL;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resp_sel_q    <= RESP_CTRL;
            local_valid_q <= 1'b0;
        end else begin
            resp_sel_q    <= resp_sel_d;
            // non-RAM accesses answer one cycle after the grant
            local_valid_q <= data_req_i & ~is_ram;
        end
    end

    // control and unmapped locations read as zero
    always_comb begin
        unique case (resp_sel_q)
            RESP_RAM: begin
                data_rvalid_o = data_bus.rvalid;
                data_rdata_o  = data_bus.rdata;
            end
            default: begin
                data_rvalid_o = local_valid_q;
                data_rdata_o  = '0;
            end
        endcase
    end

endmodule

//--- logic/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int RAM_ADDR_WIDTH = 12
) (
    input logic              clk_i,
    input logic              rst_ni,
    mem_req_if.responder     instr_bus,
    mem_req_if.responder     data_bus,
    mem_req_if.requester     ram_bus
);
    import mm_pkg::*;

    logic                      data_sel;
    logic                      data_gnt;
    logic                      instr_gnt;
    logic [RAM_ADDR_WIDTH-1:0] sel_addr;
    owner_e                    owner_d;
    owner_e                    owner_q;

    // data port has fixed priority over instruction fetches
    assign data_sel = data_bus.req;

    always_comb begin
        if (data_sel) begin
            sel_addr = data_bus.addr;
        end else begin
            sel_addr = instr_bus.addr;
        end
    end

    assign ram_bus.req   = data_bus.req | instr_bus.req;
    assign ram_bus.addr  = sel_addr;
    assign ram_bus.we    = data_sel ? data_bus.we : instr_bus.we;
    assign ram_bus.be    = data_sel ? data_bus.be : instr_bus.be;
    assign ram_bus.wdata = data_sel ? data_bus.wdata : instr_bus.wdata;

    assign data_gnt  = data_bus.req & ram_bus.gnt;
    assign instr_gnt = instr_bus.req & ~data_bus.req & ram_bus.gnt;

    assign data_bus.gnt  = data_gnt;
    assign instr_bus.gnt = instr_gnt;

    // remember who gets the response in the next cycle
    always_comb begin
        if (data_gnt) begin
            owner_d = OWN_DATA;
        end else if (instr_gnt) begin
            owner_d = OWN_INSTR;
        end else begin
            owner_d = OWN_NONE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= owner_d;
        end
    end

    // only the owner of the read in flight sees the response
    assign data_bus.rvalid  = ram_bus.rvalid && (owner_q == OWN_DATA);
    assign data_bus.rdata   = (owner_q == OWN_DATA) ? ram_bus.rdata : '0;
    assign instr_bus.rvalid = ram_bus.rvalid && (owner_q == OWN_INSTR);
    assign instr_bus.rdata  = (owner_q == OWN_INSTR) ? ram_bus.rdata : '0;

endmodule

//--- logic/sp_ram.sv
`timescale 1ns/1ps

module sp_ram #(
    parameter int RAM_ADDR_WIDTH = 12
) (
    input logic          clk_i,
    mem_req_if.responder ram_bus
);
    import mm_pkg::*;

    localparam int DEPTH = 2 ** (RAM_ADDR_WIDTH - 2);

    word_t                     mem [DEPTH];
    logic [RAM_ADDR_WIDTH-3:0] word_idx;
    logic                      rvalid_q;
    word_t                     rdata_q;

    // word index from the byte address
    assign word_idx = ram_bus.addr[RAM_ADDR_WIDTH-1:2];

    always_ff @(posedge clk_i) begin
        if (ram_bus.req) begin
            if (ram_bus.we) begin
                // merge only the enabled bytes
                for (int i = 0; i < 4; i++) begin
                    if (ram_bus.be[i]) begin
                        mem[word_idx][8*i +: 8] <= ram_bus.wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[word_idx];
            end
        end
        rvalid_q <= ram_bus.req;
    end

    // the RAM never stalls a request
    assign ram_bus.gnt    = ram_bus.req;
    assign ram_bus.rvalid = rvalid_q;
    assign ram_bus.rdata  = rdata_q;

endmodule

//--- logic/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if #(
    parameter int RAM_ADDR_WIDTH = 12
);
    import mm_pkg::*;

    // request side
    logic                      req;
    logic [RAM_ADDR_WIDTH-1:0] addr;
    logic                      we;
    be_t                       be;
    word_t                     wdata;

    // response side
    logic                      gnt;
    logic                      rvalid;
    word_t                     rdata;

    modport requester (
        output req, addr, we, be, wdata,
        input  gnt, rvalid, rdata
    );

    modport responder (
        input  req, addr, we, be, wdata,
        output gnt, rvalid, rdata
    );

endinterface

//--- logic/mm_pkg.sv
package mm_pkg;

    // basic data types of the memory system
    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;
    typedef logic [4:0]  irq_id_t;

    // memory-mapped control locations
    localparam word_t ADDR_STATUS     = 32'h2000_0000;
    localparam word_t ADDR_EXIT       = 32'h2000_0004;
    localparam word_t ADDR_TIMER_MASK = 32'h1500_0000;
    localparam word_t ADDR_TIMER_CNT  = 32'h1500_0004;

    // values written to the status location by the test program
    localparam word_t STATUS_PASS_CODE = 32'd123456789;
    localparam word_t STATUS_FAIL_CODE = 32'd1;

    // timer interrupt id, which is also its enable bit in the mask
    localparam irq_id_t TIMER_IRQ_ID = 5'd7;

    // requester whose RAM response comes back next
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_INSTR,
        OWN_DATA
    } owner_e;

    // where the data-port response is taken from
    typedef enum logic {
        RESP_RAM,
        RESP_CTRL
    } resp_sel_e;

endpackage
